// ==== hdl/lcd_pkg.sv ====
/* lcd display link shared definitions
   register map, entry fifo sizing, bus and panel types */
package lcd_pkg;

	// entry fifo sizing
	localparam int fifo_depth = 8;
	localparam int fifo_cnt_w = 4;                  // holds 0 to fifo_depth
	localparam int fifo_ptr_w = $clog2(fifo_depth); // pointers wrap on their own

	// word addresses on the 2-bit bus address
	localparam logic [1:0] adr_ctrl   = 2'd0; // rw, panel reset level and divider
	localparam logic [1:0] adr_cmd    = 2'd1; // wo, command byte
	localparam logic [1:0] adr_pix    = 2'd2; // wo, rgb565 pixel
	localparam logic [1:0] adr_status = 2'd3; // ro

	localparam logic [7:0] div_reset = 8'd3; // half period is div+1 clocks

	// wishbone classic, master side
	typedef struct packed {
		logic        cyc;
		logic        stb;
		logic        we;
		logic [1:0]  adr;   // word address
		logic [31:0] dat_w;
	} wb_req_t;

	// wishbone classic, slave side
	typedef struct packed {
		logic        ack;   // one cycle per access
		logic [31:0] dat_r;
	} wb_rsp_t;

	// command view of an entry payload
	typedef struct packed {
		logic [7:0] pad;  // not sent
		logic [7:0] code; // command byte
	} lcd_cmd_view_t;

	// one payload word, decoded by dc
	typedef union packed {
		lcd_cmd_view_t cmd; // dc 0
		logic [15:0]   pix; // dc 1, rgb565
	} lcd_payload_u;

	// fifo entry, 17 bits
	typedef struct packed {
		logic         dc; // 0 command, 1 pixel
		lcd_payload_u payload;
	} lcd_entry_t;

	// panel pin set
	typedef struct packed {
		logic scl; // spi clock, idles low
		logic sdo; // data to panel
		logic cs;  // active low select
		logic dc;  // data/command
		logic rst; // panel reset, active low
	} lcd_pins_t;

endpackage

// ==== hdl/lcd_wb_regs.sv ====
/* lcd register block
   wishbone classic slave, ctrl and status regs, command and pixel pushes */
module lcd_wb_regs import lcd_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  wb_req_t               req,
	output wb_rsp_t               rsp,
	output lcd_entry_t            push_entry,
	output logic                  push,
	input  logic                  full,
	input  logic [fifo_cnt_w-1:0] count,
	input  logic                  busy,
	output logic [7:0]            div,
	output logic                  panel_rst
);

	logic         ack_q;    // registered ack
	logic [31:0]  dat_r_q;  // registered read data
	logic         access;   // cycle seen, ack cycle masked out
	logic         fifo_adr; // cmd or pix address
	logic         stall;    // push to a full fifo
	logic         ack_next;
	logic [7:0]   div_q;
	logic         rst_q;    // lcd_rst level
	logic [31:0]  rd_data;
	lcd_payload_u payload;

	// stb still high during the ack cycle, so skip it
	assign access   = req.cyc && req.stb && !ack_q;
	assign fifo_adr = (req.adr == adr_cmd) || (req.adr == adr_pix);
	assign stall    = req.we && fifo_adr && full;
	assign ack_next = access && !stall; // held off until space appears

	// push on the same edge that raises ack
	assign push = ack_next && req.we && fifo_adr;

	// pick the union view from the address
	always_comb begin
		payload = '0;
		if (req.adr == adr_pix) begin
			payload.pix = req.dat_w[15:0]; // whole halfword
		end else begin
			payload.cmd.pad  = 8'h00;
			payload.cmd.code = req.dat_w[7:0]; // low byte only
		end
	end

	assign push_entry.dc      = (req.adr == adr_pix);
	assign push_entry.payload = payload;

	// read mux
	always_comb begin
		rd_data = 32'h0;
		case (req.adr)
			adr_ctrl: begin
				rd_data[15:8] = div_q;
				rd_data[0]    = rst_q;
			end
			adr_status: begin
				rd_data[0]    = busy;
				rd_data[1]    = full;
				rd_data[11:8] = count;
			end
			default: rd_data = 32'h0; // cmd and pix read as zero
		endcase
	end

	// ack and ctrl register
	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q <= 1'b0;
			div_q <= div_reset;
			rst_q <= 1'b0; // panel held in reset
		end else begin
			ack_q <= ack_next;
			if (ack_next && req.we && (req.adr == adr_ctrl)) begin
				div_q <= req.dat_w[15:8];
				rst_q <= req.dat_w[0];
			end
		end
	end

	// read data follows ack
	always_ff @(posedge clk) begin
		if (ack_next) begin
			dat_r_q <= req.we ? 32'h0 : rd_data;
		end
	end

	assign rsp       = '{ack: ack_q, dat_r: dat_r_q};
	assign div       = div_q;
	assign panel_rst = rst_q;

endmodule

// ==== hdl/lcd_entry_fifo.sv ====
/* lcd entry fifo
   circular buffer with occupancy count and zero latency head */
module lcd_entry_fifo import lcd_pkg::*; (
	input  logic                  clk,
	input  logic                  rst,
	input  lcd_entry_t            wr_entry,
	input  logic                  push,
	output logic                  full,
	output lcd_entry_t            rd_entry,
	input  logic                  pop,
	output logic                  empty,
	output logic [fifo_cnt_w-1:0] count
);

	lcd_entry_t            mem [fifo_depth]; // entry storage
	logic [fifo_ptr_w-1:0] wr_ptr;
	logic [fifo_ptr_w-1:0] rd_ptr;
	logic [fifo_cnt_w-1:0] cnt_q;
	logic                  do_push;
	logic                  do_pop;

	assign full  = (cnt_q == fifo_cnt_w'(fifo_depth));
	assign empty = (cnt_q == '0);
	assign count = cnt_q;

	// guard against overflow and underflow
	assign do_push = push && !full;
	assign do_pop  = pop && !empty;

	// head entry straight from storage
	assign rd_entry = mem[rd_ptr];

	// storage write
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= wr_entry;
		end
	end

	// pointers and count
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt_q  <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1; // wraps at depth
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			// push and pop together leave the count alone
			case ({do_push, do_pop})
				2'b10:   cnt_q <= cnt_q + 1'b1;
				2'b01:   cnt_q <= cnt_q - 1'b1;
				default: cnt_q <= cnt_q;
			endcase
		end
	end

endmodule

// ==== hdl/lcd_spi_tx.sv ====
/* lcd spi transmitter
   mode 0 serializer, 8-bit command or 16-bit pixel frames, msb first */
module lcd_spi_tx import lcd_pkg::*; (
	input  logic       clk,
	input  logic       rst,
	input  lcd_entry_t entry,
	input  logic       empty,
	output logic       pop,
	input  logic [7:0] div,
	input  logic       panel_rst,
	output logic       busy,
	output lcd_pins_t  pins
);

	typedef enum logic [1:0] {
		st_idle,
		st_shift,
		st_gap
	} state_t;

	state_t      state;
	logic [7:0]  half_cnt;  // clocks into the current half period
	logic [7:0]  div_lat;   // divider for the running frame
	logic [3:0]  bit_cnt;   // bits left after the current one
	logic [15:0] shift_q;   // msb is on sdo
	logic [15:0] load_word;
	logic        half_done;
	logic        gap_done;
	logic        start;
	logic        fall;      // scl high to low, next bit
	lcd_pins_t   pins_q;

	assign half_done = (half_cnt == div_lat);
	assign gap_done  = (state == st_gap) && half_done;

	// frame may start straight out of the gap
	assign start = !empty && ((state == st_idle) || gap_done);
	assign pop   = start; // head is valid this cycle
	assign busy  = (state != st_idle);

	// command byte left aligned, pixel as is
	assign load_word = entry.dc ? entry.payload.pix : {entry.payload.cmd.code, 8'h00};

	// end of a high half with bits still to go
	assign fall = (state == st_shift) && half_done && pins_q.scl && (bit_cnt != 4'd0);

	// fsm, counters and pins
	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= st_idle;
			half_cnt <= '0;
			div_lat  <= '0;
			bit_cnt  <= '0;
			pins_q   <= '{scl: 1'b0, sdo: 1'b0, cs: 1'b1, dc: 1'b0, rst: 1'b0};
		end else begin
			pins_q.rst <= panel_rst; // registered straight through
			if (start) begin
				state      <= st_shift;
				half_cnt   <= '0;
				div_lat    <= div; // divider sampled per frame
				bit_cnt    <= entry.dc ? 4'd15 : 4'd7;
				pins_q.cs  <= 1'b0;
				pins_q.dc  <= entry.dc;
				pins_q.scl <= 1'b0;
				pins_q.sdo <= load_word[15]; // msb out with cs
			end else begin
				case (state)
					st_shift: begin
						if (!half_done) begin
							half_cnt <= half_cnt + 1'b1;
						end else begin
							half_cnt <= '0;
							if (!pins_q.scl) begin
								pins_q.scl <= 1'b1; // panel samples here
							end else if (bit_cnt == 4'd0) begin
								pins_q.scl <= 1'b0; // last bit done
								pins_q.cs  <= 1'b1;
								pins_q.sdo <= 1'b0;
								state      <= st_gap;
							end else begin
								pins_q.scl <= 1'b0;
								pins_q.sdo <= shift_q[14]; // next bit while low
								bit_cnt    <= bit_cnt - 1'b1;
							end
						end
					end
					st_gap: begin
						// cs high for div+1 clocks
						if (half_done) begin
							state <= st_idle;
						end else begin
							half_cnt <= half_cnt + 1'b1;
						end
					end
					default: half_cnt <= '0;
				endcase
			end
		end
	end

	// data shifter
	always_ff @(posedge clk) begin
		if (start) begin
			shift_q <= load_word;
		end else if (fall) begin
			shift_q <= {shift_q[14:0], 1'b0};
		end
	end

	assign pins = pins_q;

endmodule

// ==== hdl/lcd_subsys.sv ====
/* lcd display link top
   register block feeding the entry fifo and the spi transmitter */
module lcd_subsys import lcd_pkg::*; (
	input  logic      clk,
	input  logic      rst,
	input  wb_req_t   req,
	output wb_rsp_t   rsp,
	output lcd_pins_t pins
);

	lcd_entry_t            push_entry; // regs to fifo
	logic                  push;
	logic                  full;
	lcd_entry_t            head_entry; // fifo to serializer
	logic                  pop;
	logic                  empty;
	logic [fifo_cnt_w-1:0] count;      // for status
	logic                  busy;
	logic [7:0]            div;
	logic                  panel_rst;

	// producer, bus side
	lcd_wb_regs u_regs (
		.clk        (clk),
		.rst        (rst),
		.req        (req),
		.rsp        (rsp),
		.push_entry (push_entry),
		.push       (push),
		.full       (full),
		.count      (count),
		.busy       (busy),
		.div        (div),
		.panel_rst  (panel_rst)
	);

	lcd_entry_fifo u_fifo (
		.clk      (clk),
		.rst      (rst),
		.wr_entry (push_entry),
		.push     (push),
		.full     (full),
		.rd_entry (head_entry),
		.pop      (pop),
		.empty    (empty),
		.count    (count)
	);

	// consumer, panel side
	lcd_spi_tx u_spi (
		.clk       (clk),
		.rst       (rst),
		.entry     (head_entry),
		.empty     (empty),
		.pop       (pop),
		.div       (div),
		.panel_rst (panel_rst),
		.busy      (busy),
		.pins      (pins)
	);

endmodule

// ==== verification/tb_lcd_subsys.sv ====
/* lcd display link testbench
   replays the bus trace as a wishbone master and decodes the spi pins into frames */
module tb_lcd_subsys import lcd_pkg::*; ();

	logic      clk = 1'b0;
	logic      rst;
	wb_req_t   req;
	wb_rsp_t   rsp;
	lcd_pins_t pins;

	// bus operations from the trace
	logic [7:0]  op_kind [$];
	logic [1:0]  op_adr  [$];
	logic [31:0] op_dat  [$];
	int          op_fcnt [$]; // frames listed ahead of this op

	// expected frames in file order
	logic        exp_dc   [$];
	logic [15:0] exp_data [$];
	logic [7:0]  exp_div  [$]; // divider in force for that frame

	int     n_lines = 0;  // trace lines without comments
	int     n_frames = 0;
	bit     loaded = 1'b0;
	int     err_val = 0;  // wrong values
	int     err_misc = 0; // lost, extra or stalled
	int     seed;
	int     frames_done = 0;
	longint cyc = 0;      // clk count for bit timing

	// monitor state
	logic        prev_cs = 1'b1;
	logic        prev_scl = 1'b0;
	logic        in_frame = 1'b0;
	int          nbits;
	logic [15:0] shreg;
	logic        frame_dc;
	longint      last_rise;
	int          rise_gap;
	int          want_gap;

	lcd_subsys u_dut (
		.clk  (clk),
		.rst  (rst),
		.req  (req),
		.rsp  (rsp),
		.pins (pins)
	);

	always #4 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	task automatic report_value(input string name, input logic [31:0] exp, input logic [31:0] got);
		$display("ERR %s exp %h got %h at %0t", name, exp, got, $time);
		err_val++;
	endtask

	task automatic finish_run();
		$display("error counts: %0d value, %0d other", err_val, err_misc);
		if (err_val + err_misc == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	endtask

	// whole trace into queues before the run starts
	task automatic load_trace();
		int         fd;
		int         n;
		logic [7:0] kind;
		logic [31:0] a;
		logic [31:0] b;
		logic [7:0] cur_div;
		string      line;
		cur_div = div_reset;
		fd = $fopen("verification/lcd_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file verification/lcd_trace.txt");
			err_misc++;
		end else begin
			while (!$feof(fd)) begin
				n = $fscanf(fd, " %c", kind);
				if (n != 1) break;
				if (kind == "#") begin
					n = $fgets(line, fd); // rest of a comment line
				end else begin
					n = $fscanf(fd, "%h %h", a, b);
					if (n != 2) begin
						$display("trace line of kind %c is missing its fields", kind);
						err_misc++;
					end
					n_lines++;
					if (kind == "F") begin
						exp_dc.push_back(a[0]);
						exp_data.push_back(b[15:0]);
						exp_div.push_back(cur_div);
						n_frames++;
					end else begin
						if (kind == "W" && a[1:0] == adr_ctrl) cur_div = b[15:8]; // next frames
						op_kind.push_back(kind);
						op_adr.push_back(a[1:0]);
						op_dat.push_back(b);
						op_fcnt.push_back(n_frames);
					end
				end
			end
			$fclose(fd);
		end
		loaded = 1'b1;
	endtask

	// one classic cycle held until ack
	task automatic bus_access(input logic we, input logic [1:0] adr, input logic [31:0] dat,
		output logic [31:0] rdata);
		req = '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat_w: dat};
		do begin
			@(posedge clk);
			#1;
		end while (!rsp.ack);
		rdata = rsp.dat_r;
		req   = '0;
	endtask

	task automatic wait_frames(input int n);
		while (frames_done < n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// status during the burst
	task automatic check_status(input logic [31:0] s);
		logic [3:0] cnt;
		cnt = s[11:8];
		if (cnt > 4'd8) report_value("status.count (max 8)", 32'd8, 32'(cnt));
		if (s[1] !== (cnt == 4'd8)) report_value("status.full", 32'(cnt == 4'd8), 32'(s[1]));
		if (s[0] !== 1'b1) report_value("status.busy", 32'd1, 32'(s[0]));
	endtask

	// closed frame against the queue head
	task automatic check_frame();
		logic [15:0] want;
		int          want_bits;
		if (exp_dc.size() == 0) begin
			$display("extra frame with dc %0d seen on the panel pins at %0t", frame_dc, $time);
			err_misc++;
		end else begin
			want_bits = exp_dc[0] ? 16 : 8;
			want      = exp_dc[0] ? exp_data[0] : {8'h00, exp_data[0][7:0]};
			if (nbits != want_bits) report_value("frame bits", 32'(want_bits), 32'(nbits));
			if (frame_dc !== exp_dc[0]) report_value("pins.dc", 32'(exp_dc[0]), 32'(frame_dc));
			if (shreg !== want) report_value("pins.sdo data", 32'(want), 32'(shreg));
			void'(exp_dc.pop_front());
			void'(exp_data.pop_front());
			void'(exp_div.pop_front());
			frames_done++;
		end
	endtask

	// frame monitor works on values sampled at each edge
	always @(posedge clk) begin
		if (!rst) begin
			if (prev_cs && !pins.cs) begin // cs falls
				in_frame  = 1'b1;
				nbits     = 0;
				shreg     = '0;
				frame_dc  = pins.dc;
				last_rise = -1;
			end
			if (in_frame && !prev_scl && pins.scl) begin
				shreg    = {shreg[14:0], pins.sdo}; // msb first
				nbits++;
				rise_gap = int'(cyc - last_rise);
				want_gap = (exp_div.size() > 0) ? 2 * (int'(exp_div[0]) + 1) : rise_gap;
				if (last_rise >= 0 && rise_gap != want_gap)
					report_value("scl period", 32'(want_gap), 32'(rise_gap));
				last_rise = cyc;
			end
			if (in_frame && pins.cs) begin // cs back high
				in_frame = 1'b0;
				check_frame();
			end
		end
		prev_cs  = pins.cs;
		prev_scl = pins.scl;
	end

	// watchdog sized from the trace length
	initial begin
		longint limit;
		wait (loaded);
		limit = longint'(n_lines) * 16 * 2 * 256 * 8 + 100000;
		#(limit);
		$display("watchdog expired at %0t, the bus or the frame output stalled", $time);
		err_misc++;
		finish_run();
	end

	// bus master
	initial begin
		logic [31:0] rdata;
		logic        gap_mode;
		int          gap;
		int          drain;
		rst      = 1'b1;
		req      = '0;
		seed     = 32'hf80db95e;
		gap_mode = 1'b1; // random idle gaps unless the trace says otherwise
		load_trace();
		repeat (5) @(posedge clk);
		#1;
		rst = 1'b0;
		if (pins.cs !== 1'b1) report_value("pins.cs", 32'd1, 32'(pins.cs));
		if (pins.scl !== 1'b0) report_value("pins.scl", 32'd0, 32'(pins.scl));
		if (pins.rst !== 1'b0) report_value("pins.rst", 32'd0, 32'(pins.rst));
		if (rsp.ack !== 1'b0) report_value("rsp.ack", 32'd0, 32'(rsp.ack));
		foreach (op_kind[i]) begin
			case (op_kind[i])
				"G": gap_mode = op_dat[i][0];
				"W": begin
					if (op_adr[i] == adr_ctrl) wait_frames(op_fcnt[i]); // earlier frames out first
					bus_access(1'b1, op_adr[i], op_dat[i], rdata);
					if (op_adr[i] == adr_ctrl) begin
						@(posedge clk);
						#1;
						if (pins.rst !== op_dat[i][0])
							report_value("pins.rst", 32'(op_dat[i][0]), 32'(pins.rst));
					end
				end
				"R": begin
					bus_access(1'b0, op_adr[i], 32'h0, rdata);
					if (rdata !== op_dat[i])
						report_value($sformatf("rsp.dat_r adr %0d", op_adr[i]), op_dat[i], rdata);
				end
				"S": begin
					bus_access(1'b0, op_adr[i], 32'h0, rdata);
					check_status(rdata);
				end
				default: begin
					$display("unknown trace line kind %c, its operation was not run", op_kind[i]);
					err_misc++;
				end
			endcase
			if (gap_mode) begin
				gap = $random(seed) & 3; // 0 to 3 idle cycles
				repeat (gap) begin
					@(posedge clk);
					#1;
				end
			end
		end
		drain = 0;
		while (frames_done < n_frames && drain < 100000) begin
			@(posedge clk);
			drain++;
		end
		repeat (2000) @(posedge clk); // room for any extra frame
		if (exp_dc.size() != 0) begin
			$display("%0d expected frames never appeared on the panel pins", exp_dc.size());
			err_misc++;
		end
		finish_run();
	end

endmodule

// ==== verification/lcd_trace.txt ====
# columns are kind, a, b in hex. W adr data writes, R adr expected reads, F dc data is a frame
# G 0 mode sets idle gaps (1 random, 0 none) and S 3 0 reads status during the burst
R 3 00000000
R 0 00000300
R 1 00000000
W 0 00000301
R 0 00000301
W 1 00000011
F 0 0011
W 1 ffffff29
F 0 0029
W 2 0000f800
F 1 f800
W 2 abcd07e0
F 1 07e0
W 0 fe000501
R 0 00000501
W 2 0000a5c3
F 1 a5c3
W 1 0000002c
F 0 002c
W 0 00001401
R 0 00001401
G 0 00000000
W 1 00000036
W 2 00001234
W 2 00002345
W 2 00003456
W 2 00004567
W 2 00005678
W 2 00006789
W 2 0000789a
W 2 000089ab
W 1 0000003c
S 3 00000000
W 2 00009abc
W 2 0000abcd
F 0 0036
F 1 1234
F 1 2345
F 1 3456
F 1 4567
F 1 5678
F 1 6789
F 1 789a
F 1 89ab
F 0 003c
F 1 9abc
F 1 abcd

// ==== verilog.f ====
hdl/lcd_pkg.sv
hdl/lcd_wb_regs.sv
hdl/lcd_entry_fifo.sv
hdl/lcd_spi_tx.sv
hdl/lcd_subsys.sv
verification/tb_lcd_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the lcd display link testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f verilog.f --top-module tb_lcd_subsys -o tb_lcd_subsys \
	&& ./obj_dir/tb_lcd_subsys | tee /dev/stderr | grep -F "All tests passed!" > /dev/null \
	&& echo "simulation run PASSED" \
	|| { echo "simulation run FAILED"; exit 1; }
